// ==== rtl/mdec_consts.svh ====
//------------------------------------------------------------
// Shared constants for the MDEC colour stage
// Buffer depths, address widths and the YCbCr to RGB
// coefficients; include this in any module that sizes a buffer
// or does the colour math
//------------------------------------------------------------
`ifndef MDEC_CONSTS_SVH
`define MDEC_CONSTS_SVH

//------------------------------------------------------------
// Buffers
//------------------------------------------------------------
`define MDEC_CHROMA_DEPTH	64	// One 8x8 block per chroma plane
`define MDEC_PIX_DEPTH		256	// Full 16x16 macroblock of pixels

`define MDEC_CHROMA_AW		6	// log2 of chroma depth
`define MDEC_PIX_AW			8	// log2 of pixel depth

//------------------------------------------------------------
// Conversion coefficients, units of 1/256
//------------------------------------------------------------
// R gets Cr, B gets Cb, G gets both subtracted
`define MDEC_K_RCR			359	// ~1.402
`define MDEC_K_GCB			88	// ~0.344
`define MDEC_K_GCR			183	// ~0.714
`define MDEC_K_BCB			454	// ~1.772

`endif

// ==== rtl/mdec_pkg.sv ====
//------------------------------------------------------------
// Types shared across the MDEC colour stage
// Samples, packed RGB pixels and the block kind tag
//------------------------------------------------------------
package mdec_pkg;

	// Decoded sample from the inverse transform, Y, Cr or Cb
	typedef logic signed [7:0] sample_t;

	// One output pixel, 8 bits per channel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Tag on each incoming sample
	typedef enum logic [1:0] {
		BLK_CR   = 2'd0,
		BLK_CB   = 2'd1,
		BLK_Y    = 2'd2,
		BLK_NONE = 2'd3	// Unused code, dropped by the top
	} blk_kind_t;

endpackage

// ==== rtl/mdec_block_ram.sv ====
//------------------------------------------------------------
// Simple dual-port buffer, one write port, registered read
// Payload type set by T_DATA; serves chroma and pixel storage
// Read of an address written in the same cycle gives old data
//------------------------------------------------------------
`timescale 1ns/100ps

module mdec_block_ram #(
	parameter type T_DATA = logic [7:0],	// Payload per entry
	parameter int  DEPTH  = 64				// Number of entries
) (
	input  logic                     i_clk,
	input  logic                     i_wr,		// Write strobe
	input  logic [$clog2(DEPTH)-1:0] i_wadr,
	input  T_DATA                    i_wdata,
	input  logic [$clog2(DEPTH)-1:0] i_radr,	// Always reading
	output T_DATA                    o_rdata	// One clock after i_radr
);

	T_DATA mem [DEPTH];	// No reset on contents

	// Write port
	always_ff @(posedge i_clk)
	begin
		if (i_wr)
			mem[i_wadr] <= i_wdata;
	end

	// Registered read, read-before-write on collision
	always_ff @(posedge i_clk)
	begin
		o_rdata <= mem[i_radr];
	end

endmodule

// ==== rtl/mdec_yuv2rgb_core.sv ====
//------------------------------------------------------------
// YCbCr to RGB matrix, purely combinational
// Fixed-point products in 1/256, arithmetic shift, clamp to
// -128..127, then Y-only bypass and optional +128 offset
//------------------------------------------------------------
`timescale 1ns/100ps
`include "mdec_consts.svh"

module mdec_yuv2rgb_core (
	input  logic              i_yonly,	// Monochrome, all channels = Y
	input  logic              i_signed,	// 0: offset result by 128
	input  mdec_pkg::sample_t i_y,
	input  mdec_pkg::sample_t i_cr,
	input  mdec_pkg::sample_t i_cb,
	output mdec_pkg::rgb_t    o_rgb
);

	// Coefficients as signed so products keep the chroma sign
	localparam logic signed [10:0] K_RCR = 11'(`MDEC_K_RCR);
	localparam logic signed [10:0] K_GCB = 11'(`MDEC_K_GCB);
	localparam logic signed [10:0] K_GCR = 11'(`MDEC_K_GCR);
	localparam logic signed [10:0] K_BCB = 11'(`MDEC_K_BCB);

	logic signed [18:0] r_prod, gb_prod, gr_prod, b_prod;
	logic signed [18:0] r_sum, g_sum, b_sum;
	mdec_pkg::sample_t  r_sat, g_sat, b_sat;

	// Clamp wide sum into sample range
	function automatic mdec_pkg::sample_t sat8(input logic signed [18:0] v);
		if (v > 19'sd127)
			return 8'sh7f;
		else if (v < -19'sd128)
			return 8'sh80;
		else
			return v[7:0];
	endfunction

	// Signed passes as is, unsigned flips the top bit (+128)
	function automatic logic [7:0] to_out(input mdec_pkg::sample_t s, input logic sgn);
		return sgn ? s : {~s[7], s[6:0]};
	endfunction

	//------------------------------------------------------------
	// Matrix
	//------------------------------------------------------------
	assign r_prod  = i_cr * K_RCR;
	assign gb_prod = i_cb * K_GCB;
	assign gr_prod = i_cr * K_GCR;
	assign b_prod  = i_cb * K_BCB;

	assign r_sum = i_y + (r_prod >>> 8);
	assign g_sum = i_y - ((gb_prod + gr_prod) >>> 8);	// Sum first, one shift
	assign b_sum = i_y + (b_prod >>> 8);

	// Y-only skips the matrix entirely
	assign r_sat = i_yonly ? i_y : sat8(r_sum);
	assign g_sat = i_yonly ? i_y : sat8(g_sum);
	assign b_sat = i_yonly ? i_y : sat8(b_sum);

	// Output format
	assign o_rgb.r = to_out(r_sat, i_signed);
	assign o_rgb.g = to_out(g_sat, i_signed);
	assign o_rgb.b = to_out(b_sat, i_signed);

endmodule

// ==== rtl/mdec_yuv2rgb_stage.sv ====
//------------------------------------------------------------
// Colour conversion stage, one pixel per clock
// Cycle n: Y write, chroma read address and pixel index formed
// Cycle n+1: chroma data back, core converts, pixel strobed out
//------------------------------------------------------------
`timescale 1ns/100ps
`include "mdec_consts.svh"

module mdec_yuv2rgb_stage (
	input  logic                         i_clk,
	input  logic                         i_rst,

	// Y sample in
	input  logic                         i_wr,		// Y write strobe
	input  logic                         i_yonly,
	input  logic                         i_signed,
	input  logic [5:0]                   i_idx,		// Raster in 8x8 block
	input  mdec_pkg::sample_t            i_val,
	input  logic [1:0]                   i_yblk,	// [0] right, [1] bottom

	// Chroma buffers, both read at same address
	output logic [`MDEC_CHROMA_AW-1:0]   o_chroma_adr,
	input  mdec_pkg::sample_t            i_cr,		// Valid cycle n+1
	input  mdec_pkg::sample_t            i_cb,

	// Pixel write stream
	output logic                         o_wpix,
	output logic [`MDEC_PIX_AW-1:0]      o_pix,
	output mdec_pkg::rgb_t               o_rgb
);

	//------------------------------------------------------------
	// Cycle n, addressing
	//------------------------------------------------------------
	logic [2:0] col, row;
	logic       half_x, half_y;
	logic [`MDEC_PIX_AW-1:0] pix_adr;

	assign col    = i_idx[2:0];
	assign row    = i_idx[5:3];
	assign half_x = i_yblk[0];
	assign half_y = i_yblk[1];

	// 4:2:0, one chroma per 2x2 luma
	assign o_chroma_adr = {half_y, row[2:1], half_x, col[2:1]};

	// Raster in 16x16 macroblock, or linear for Y-only
	assign pix_adr = i_yonly ? {2'b00, i_idx}
	                         : {half_y, row, half_x, col};

	//------------------------------------------------------------
	// Pipeline register, aligns Y with buffer read latency
	//------------------------------------------------------------
	mdec_pkg::sample_t       p_y;
	logic [`MDEC_PIX_AW-1:0] p_pix;
	logic                    p_wpix;
	logic                    p_yonly;
	logic                    p_signed;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			p_wpix <= 1'b0;
		else
			p_wpix <= i_wr;
	end

	// Payload and context, follow the strobe
	always_ff @(posedge i_clk)
	begin
		p_y      <= i_val;
		p_pix    <= pix_adr;
		p_yonly  <= i_yonly;	// Mode travels with its sample
		p_signed <= i_signed;
	end

	//------------------------------------------------------------
	// Cycle n+1, convert
	//------------------------------------------------------------
	mdec_yuv2rgb_core u_core (
		.i_yonly  (p_yonly),
		.i_signed (p_signed),
		.i_y      (p_y),
		.i_cr     (i_cr),
		.i_cb     (i_cb),
		.o_rgb    (o_rgb)
	);

	assign o_wpix = p_wpix;
	assign o_pix  = p_pix;

endmodule

// ==== rtl/mdec_color_top.sv ====
//------------------------------------------------------------
// MDEC colour stage top
// Routes tagged samples: Cr/Cb into chroma buffers, Y into the
// conversion stage; converted pixels fill a 256-entry buffer
// that the host reads back with one clock latency
//------------------------------------------------------------
`timescale 1ns/100ps
`include "mdec_consts.svh"

module mdec_color_top (
	input  logic                    i_clk,
	input  logic                    i_rst,

	// Sample input from inverse transform
	input  logic                    i_wr,
	input  mdec_pkg::blk_kind_t     i_kind,
	input  logic [5:0]              i_idx,
	input  mdec_pkg::sample_t       i_val,
	input  logic [1:0]              i_yblk,
	input  logic                    i_y_only,
	input  logic                    i_signed,

	// Host readback
	input  logic [`MDEC_PIX_AW-1:0] i_rd_adr,

	// Pixel write stream
	output logic                    o_wpix,
	output logic [`MDEC_PIX_AW-1:0] o_pix,
	output mdec_pkg::rgb_t          o_rgb,
	output mdec_pkg::rgb_t          o_rd_rgb	// One clock after i_rd_adr
);

	//------------------------------------------------------------
	// Kind decode
	//------------------------------------------------------------
	logic wr_cr, wr_cb, y_wr;

	assign wr_cr = i_wr && (i_kind == mdec_pkg::BLK_CR);
	assign wr_cb = i_wr && (i_kind == mdec_pkg::BLK_CB);
	assign y_wr  = i_wr && (i_kind == mdec_pkg::BLK_Y);
	// BLK_NONE falls through, nothing written

	logic [`MDEC_CHROMA_AW-1:0] chroma_adr;
	mdec_pkg::sample_t          cr_val, cb_val;

	// Chroma buffers
	mdec_block_ram #(
		.T_DATA (mdec_pkg::sample_t),
		.DEPTH  (`MDEC_CHROMA_DEPTH)
	) u_cr_ram (
		.i_clk   (i_clk),
		.i_wr    (wr_cr),
		.i_wadr  (i_idx),
		.i_wdata (i_val),
		.i_radr  (chroma_adr),
		.o_rdata (cr_val)
	);

	mdec_block_ram #(
		.T_DATA (mdec_pkg::sample_t),
		.DEPTH  (`MDEC_CHROMA_DEPTH)
	) u_cb_ram (
		.i_clk   (i_clk),
		.i_wr    (wr_cb),
		.i_wadr  (i_idx),
		.i_wdata (i_val),
		.i_radr  (chroma_adr),
		.o_rdata (cb_val)
	);

	//------------------------------------------------------------
	// Conversion
	//------------------------------------------------------------
	mdec_yuv2rgb_stage u_stage (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_wr         (y_wr),
		.i_yonly      (i_y_only),
		.i_signed     (i_signed),
		.i_idx        (i_idx),
		.i_val        (i_val),
		.i_yblk       (i_yblk),
		.o_chroma_adr (chroma_adr),
		.i_cr         (cr_val),		// Arrives with registered Y
		.i_cb         (cb_val),
		.o_wpix       (o_wpix),
		.o_pix        (o_pix),
		.o_rgb        (o_rgb)
	);

	// Pixel buffer, written from stage, read by host
	mdec_block_ram #(
		.T_DATA (mdec_pkg::rgb_t),
		.DEPTH  (`MDEC_PIX_DEPTH)
	) u_pix_ram (
		.i_clk   (i_clk),
		.i_wr    (o_wpix),
		.i_wadr  (o_pix),
		.i_wdata (o_rgb),
		.i_radr  (i_rd_adr),
		.o_rdata (o_rd_rgb)
	);

endmodule

// ==== sim/mdec_color_chk.sv ====
//------------------------------------------------------------
// Bound checker for the MDEC colour top
// Reset state of the pixel strobe, strobe latency and pixel
// address against the Y write one cycle earlier
//------------------------------------------------------------
`timescale 1ns/100ps
`include "mdec_consts.svh"

module mdec_color_chk (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_wr,
	input  mdec_pkg::blk_kind_t     i_kind,
	input  logic [5:0]              i_idx,
	input  logic [1:0]              i_yblk,
	input  logic                    i_y_only,
	input  logic                    o_wpix,
	input  logic [`MDEC_PIX_AW-1:0] o_pix
);

	logic                    y_wr;		// Y sample accepted this cycle
	logic [`MDEC_PIX_AW-1:0] exp_pix;	// Where that sample must land

	assign y_wr    = i_wr && (i_kind == mdec_pkg::BLK_Y);
	assign exp_pix = i_y_only ? {2'b00, i_idx}
	                          : {i_yblk[1], i_idx[5:3], i_yblk[0], i_idx[2:0]};

	// Strobe held low through reset and the cycle after
	a_rst_low: assert property (@(posedge i_clk) i_rst |=> !o_wpix)
		else $error("o_wpix high during or right after reset");

	// One cycle from Y write to pixel strobe
	a_strobe: assert property (@(posedge i_clk) disable iff (i_rst) o_wpix == $past(y_wr))
		else $error("o_wpix does not follow the Y write by one cycle");

	a_index: assert property (@(posedge i_clk) disable iff (i_rst)
		o_wpix |-> (o_pix == $past(exp_pix)))
		else $error("o_pix does not match the registered index and block");

endmodule

bind mdec_color_top mdec_color_chk u_chk (
	.i_clk    (i_clk),
	.i_rst    (i_rst),
	.i_wr     (i_wr),
	.i_kind   (i_kind),
	.i_idx    (i_idx),
	.i_yblk   (i_yblk),
	.i_y_only (i_y_only),
	.o_wpix   (o_wpix),
	.o_pix    (o_pix)
);

// ==== sim/mdec_color_tb.sv ====
//------------------------------------------------------------
// Testbench for the MDEC colour top
// Random macroblocks from a fixed seed, a reference model of the
// chroma buffers, the colour matrix and the pixel buffer
// A negedge monitor checks every pixel strobe against the model
//------------------------------------------------------------
`timescale 1ns/100ps
`include "mdec_consts.svh"

module mdec_color_tb;

	logic                    clk, rst, wr, y_only, sgn;
	mdec_pkg::blk_kind_t     kind;
	logic [5:0]              idx;
	mdec_pkg::sample_t       val;
	logic [1:0]              yblk;
	logic [`MDEC_PIX_AW-1:0] rd_adr, pix;
	logic                    wpix;
	mdec_pkg::rgb_t          rgb, rd_rgb;

	// Reference model
	int          cr_m [64];
	int          cb_m [64];
	logic [23:0] pic [256];		// Expected pixel buffer
	bit          mon_on, pend_v;
	logic [7:0]  pend_pix;		// Pixel due next cycle
	logic [23:0] pend_rgb;
	int          n_chk, n_err, n_test, n_tfail, err_mark;

	mdec_color_top DUT (
		.i_clk (clk), .i_rst (rst), .i_wr (wr), .i_kind (kind), .i_idx (idx),
		.i_val (val), .i_yblk (yblk), .i_y_only (y_only), .i_signed (sgn),
		.i_rd_adr (rd_adr), .o_wpix (wpix), .o_pix (pix), .o_rgb (rgb),
		.o_rd_rgb (rd_rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	//------------------------------------------------------------
	// Model functions
	//------------------------------------------------------------
	function automatic int clamp8(input int v);
		return (v > 127) ? 127 : ((v < -128) ? -128 : v);
	endfunction

	function automatic logic [23:0] to_rgb(input int y, input int cr, input int cb,
		input logic yonly, input logic sgn_out);
		int r, g, b;
		if (yonly)
		begin
			r = y;	// Grey, matrix bypassed
			g = y;
			b = y;
		end
		else
		begin
			r = clamp8(y + ((`MDEC_K_RCR * cr) >>> 8));
			g = clamp8(y - ((`MDEC_K_GCB * cb + `MDEC_K_GCR * cr) >>> 8));
			b = clamp8(y + ((`MDEC_K_BCB * cb) >>> 8));
		end
		if (!sgn_out)
		begin
			r += 128;	// Unsigned, centred on 128
			g += 128;
			b += 128;
		end
		return {r[7:0], g[7:0], b[7:0]};
	endfunction

	// Raster in 16x16, or linear for Y-only
	function automatic logic [7:0] pix_index(input logic [5:0] i, input logic [1:0] b,
		input logic yonly);
		return yonly ? {2'b00, i} : {b[1], i[5:3], b[0], i[2:0]};
	endfunction

	function automatic logic [5:0] chroma_index(input logic [5:0] i, input logic [1:0] b);
		return {b[1], i[5:4], b[0], i[2:1]};	// 4:2:0
	endfunction

	function automatic int rand_sample();
		return int'($urandom % 256) - 128;
	endfunction

	function automatic int extreme_sample();
		return ($urandom % 2 == 0) ? -128 : 127;
	endfunction

	//------------------------------------------------------------
	// Checks and drivers
	//------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_chk++;
		if (got !== exp)
		begin
			n_err++;
			$display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// One sample, 1 ns after the edge; chroma model follows the write
	task automatic drive(input mdec_pkg::blk_kind_t k, input int i, input int v, input int b);
		@(posedge clk);
		#1;
		wr   = 1'b1;
		kind = k;
		idx  = 6'(i);
		val  = 8'(v);
		yblk = 2'(b);
		if (k == mdec_pkg::BLK_CR)
			cr_m[i] = v;
		else if (k == mdec_pkg::BLK_CB)
			cb_m[i] = v;
	endtask

	task automatic idle();
		@(posedge clk);
		#1;
		wr   = 1'b0;
		kind = mdec_pkg::BLK_NONE;
	endtask

	task automatic write_chroma(input bit extremes);
		for (int i = 0; i < 64; i++)
			drive(mdec_pkg::BLK_CR, i, extremes ? extreme_sample() : rand_sample(), 0);
		for (int i = 0; i < 64; i++)
			drive(mdec_pkg::BLK_CB, i, extremes ? extreme_sample() : rand_sample(), 0);
	endtask

	task automatic send_yblock(input int b, input bit extremes);
		for (int i = 0; i < 64; i++)
			drive(mdec_pkg::BLK_Y, i, extremes ? extreme_sample() : rand_sample(), b);
	endtask

	// Until no pixel is in flight, bounded
	task automatic wait_drain();
		int n;
		n = 0;
		while ((pend_v || wpix) && n < 20)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (pend_v || wpix)
		begin
			n_err++;
			$display("Timeout: pixel strobe still active 20 cycles after the last Y write");
		end
	endtask

	task automatic read_back();
		for (int a = 0; a < 256; a++)
		begin
			@(posedge clk);
			#1 rd_adr = 8'(a);
			@(posedge clk);		// Buffer registers the read
			@(negedge clk);
			check("o_rd_rgb", {8'd0, rd_rgb}, {8'd0, pic[a]});
		end
	endtask

	task automatic end_test(input string name);
		n_test++;
		if (n_err == err_mark)
			$display("test %0d  %s: ok", n_test, name);
		else
		begin
			n_tfail++;
			$display("test %0d  %s: %0d errors", n_test, name, n_err - err_mark);
		end
		err_mark = n_err;
	endtask

	//------------------------------------------------------------
	// Pixel stream monitor
	//------------------------------------------------------------
	always @(negedge clk)
	begin
		if (mon_on)
		begin
			check("o_wpix", {31'd0, wpix}, {31'd0, pend_v});
			if (pend_v)
			begin
				check("o_pix", {24'd0, pix}, {24'd0, pend_pix});
				check("o_rgb", {8'd0, rgb}, {8'd0, pend_rgb});
				pic[pend_pix] = pend_rgb;	// Buffer written at next edge
			end
			pend_v = wr && (kind == mdec_pkg::BLK_Y) && !rst;
			if (pend_v)
			begin
				pend_pix = pix_index(idx, yblk, y_only);
				pend_rgb = to_rgb(int'(val), cr_m[chroma_index(idx, yblk)],
					cb_m[chroma_index(idx, yblk)], y_only, sgn);
			end
		end
	end

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial
	begin
		int ord [4];
		int j, t;
		void'($urandom(32'h64693c1b));
		rst    = 1'b1;
		wr     = 1'b0;
		kind   = mdec_pkg::BLK_NONE;
		idx    = '0;
		val    = '0;
		yblk   = '0;
		y_only = 1'b0;
		sgn    = 1'b1;
		rd_adr = '0;
		@(posedge clk);
		mon_on = 1'b1;			// Strobe already reset
		repeat (7) @(posedge clk);
		#1 rst = 1'b0;

		repeat (6) idle();		// Strobe must stay low
		end_test("reset, strobe low");

		// Four Y blocks in shuffled order
		ord = '{0, 1, 2, 3};
		for (int k = 3; k > 0; k--)
		begin
			j      = int'($urandom % (k + 1));
			t      = ord[k];
			ord[k] = ord[j];
			ord[j] = t;
		end
		write_chroma(1'b0);
		for (int k = 0; k < 4; k++)
			send_yblock(ord[k], 1'b0);
		idle();
		wait_drain();
		end_test("colour macroblock, signed");

		read_back();
		end_test("readback of 256 pixels");

		idle();
		sgn = 1'b0;
		write_chroma(1'b1);
		for (int b = 0; b < 4; b++)
			send_yblock(b, 1'b1);
		idle();
		wait_drain();
		end_test("saturation, unsigned");

		y_only = 1'b1;
		sgn    = 1'($urandom % 2);
		for (int i = 0; i < 64; i++)
			drive(mdec_pkg::BLK_Y, i, rand_sample(), int'($urandom % 4));	// Block ignored
		idle();
		wait_drain();
		y_only = 1'b0;
		end_test("Y-only block");

		// New chroma mixed with the unused kind
		sgn = 1'b1;
		for (int i = 0; i < 64; i++)
		begin
			drive(mdec_pkg::BLK_CR, i, rand_sample(), 0);
			drive(mdec_pkg::BLK_NONE, int'($urandom % 64), rand_sample(), 0);
			drive(mdec_pkg::BLK_CB, i, rand_sample(), 0);
			drive(mdec_pkg::BLK_NONE, int'($urandom % 64), rand_sample(), 0);
		end
		send_yblock(int'($urandom % 4), 1'b0);
		idle();
		wait_drain();
		end_test("chroma rewrite, unused kind");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", n_test, n_tfail, n_chk, n_err);
		if (n_err == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/mdec_pkg.sv
rtl/mdec_block_ram.sv
rtl/mdec_yuv2rgb_core.sv
rtl/mdec_yuv2rgb_stage.sv
rtl/mdec_color_top.sv
sim/mdec_color_chk.sv
sim/mdec_color_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MDEC colour stage testbench with Verilator.
# Exit status 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f files.f --top-module mdec_color_tb -o mdec_color_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/mdec_color_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
